// File: rtl/nfcReadPagePkg.sv
`default_nettype none

package nfcReadPagePkg;

    // flash array and engine bus sizes
    localparam int NUM_WAYS = 4;
    localparam int ENGINE_COUNT = 8;

    typedef logic [NUM_WAYS-1:0] wayMask_t;
    typedef logic [5:0] opcode_t;
    typedef logic [15:0] dataLength_t;
    typedef logic [15:0] colAddress_t;
    typedef logic [23:0] rowAddress_t;
    // first bus byte sits in the top eight bits
    typedef logic [39:0] caData_t;
    typedef logic [ENGINE_COUNT-1:0] engineSelect_t;

    localparam opcode_t READ_PAGE_OPCODE = 6'b000100;

    // engine slots on the lower-level bus
    localparam int ENGINE_CMD_ADDR = 3;
    localparam int ENGINE_DATA_IN = 1;

    // second command byte of a page read
    localparam logic [7:0] READ_CONFIRM_BYTE = 8'h30;

    // count field is byte count minus one, so five address bytes
    localparam dataLength_t ADDRESS_COUNT_CODE = 16'd4;

    typedef struct packed {
        opcode_t     opcode;
        dataLength_t length;
        colAddress_t colAddress;
        rowAddress_t rowAddress;
        wayMask_t    waySelect;
    } hostCommand_t;

    typedef struct packed {
        engineSelect_t engineSelect;
        wayMask_t      targetWay;
        dataLength_t   byteCount;
        logic          caSelect;
        caData_t       caData;
    } engineRequest_t;

    // one-hot phase encoding
    typedef enum logic [8:0] {
        resetState = 9'b0_0000_0001,
        idle       = 9'b0_0000_0010,
        capture    = 9'b0_0000_0100,
        cmdIssue   = 9'b0_0000_1000,
        addrIssue  = 9'b0_0001_0000,
        cmd2Issue  = 9'b0_0010_0000,
        waitBusy   = 9'b0_0100_0000,
        waitReady  = 9'b0_1000_0000,
        dataIssue  = 9'b1_0000_0000
    } readPageState_t;

endpackage

`default_nettype wire

// File: rtl/readyBusyMonitor.sv
`timescale 1ns/100ps
`default_nettype none

module readyBusyMonitor (
    input  wire                           iSystemClock,
    input  wire                           rst,
    input  wire nfcReadPagePkg::wayMask_t targetWay,
    input  wire nfcReadPagePkg::wayMask_t readyBusy,
    output logic                          wayReady
);

    // first stage, flash lines come in asynchronously
    nfcReadPagePkg::wayMask_t maskedLines;

    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            maskedLines <= '1;
        end else begin
            // only the addressed ways count
            maskedLines <= targetWay & readyBusy;
        end
    end

    // second stage, any selected way ready
    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            wayReady <= 1'b1;
        end else begin
            wayReady <= |maskedLines;
        end
    end

endmodule

`default_nettype wire

// File: rtl/commandLatch.sv
`timescale 1ns/100ps
`default_nettype none

module commandLatch (
    input  wire                               iSystemClock,
    input  wire                               rst,
    input  wire                               capture,
    input  wire nfcReadPagePkg::hostCommand_t command,
    output nfcReadPagePkg::wayMask_t          targetWay,
    output nfcReadPagePkg::dataLength_t       length,
    output nfcReadPagePkg::caData_t           addressBytes
);

    nfcReadPagePkg::colAddress_t colAddress;
    nfcReadPagePkg::rowAddress_t rowAddress;

    // fields held for the whole command
    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            targetWay  <= '0;
            length     <= '0;
            colAddress <= '0;
            rowAddress <= '0;
        end else if (capture) begin
            targetWay  <= command.waySelect;
            length     <= command.length;
            colAddress <= command.colAddress;
            rowAddress <= command.rowAddress;
        end
    end

    // address cycles go out low byte first
    // column takes two cycles, row takes three
    assign addressBytes = {
        colAddress[7:0],
        colAddress[15:8],
        rowAddress[7:0],
        rowAddress[15:8],
        rowAddress[23:16]
    };

endmodule

`default_nettype wire

// File: rtl/readPageSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module readPageSequencer (
    input  wire                                iSystemClock,
    input  wire                                rst,
    input  wire nfcReadPagePkg::opcode_t       cmdOpcode,
    input  wire                                cmdValid,
    output logic                               cmdReady,
    output logic                               start,
    output logic                               capture,
    input  wire nfcReadPagePkg::wayMask_t      targetWay,
    input  wire nfcReadPagePkg::dataLength_t   length,
    input  wire nfcReadPagePkg::caData_t       addressBytes,
    input  wire                                wayReady,
    input  wire nfcReadPagePkg::engineSelect_t engineDone,
    output nfcReadPagePkg::engineRequest_t     engineReq,
    output logic                               transValid,
    output logic                               lastStep
);

    nfcReadPagePkg::readPageState_t state;
    nfcReadPagePkg::readPageState_t nextState;
    nfcReadPagePkg::engineSelect_t  cmdAddrSelect;
    nfcReadPagePkg::engineSelect_t  dataInSelect;
    logic                           accept;
    logic                           cmdAddrDone;
    logic                           dataDone;

    assign cmdAddrSelect = nfcReadPagePkg::engineSelect_t'(1) << nfcReadPagePkg::ENGINE_CMD_ADDR;
    assign dataInSelect  = nfcReadPagePkg::engineSelect_t'(1) << nfcReadPagePkg::ENGINE_DATA_IN;

    assign cmdAddrDone = engineDone[nfcReadPagePkg::ENGINE_CMD_ADDR];
    assign dataDone    = engineDone[nfcReadPagePkg::ENGINE_DATA_IN];

    // matching opcode while ready, anything else is dropped
    assign accept = cmdReady && cmdValid &&
                    (cmdOpcode == nfcReadPagePkg::READ_PAGE_OPCODE);

    assign start   = accept;
    // latch takes the fields on the accepting edge
    assign capture = accept;

    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            state <= nfcReadPagePkg::resetState;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            nfcReadPagePkg::resetState,
            nfcReadPagePkg::idle: begin
                nextState = accept ? nfcReadPagePkg::capture : nfcReadPagePkg::idle;
            end
            nfcReadPagePkg::capture: begin
                nextState = nfcReadPagePkg::cmdIssue;
            end
            nfcReadPagePkg::cmdIssue: begin
                if (cmdAddrDone) begin
                    nextState = nfcReadPagePkg::addrIssue;
                end
            end
            nfcReadPagePkg::addrIssue: begin
                if (cmdAddrDone) begin
                    nextState = nfcReadPagePkg::cmd2Issue;
                end
            end
            nfcReadPagePkg::cmd2Issue: begin
                if (cmdAddrDone) begin
                    nextState = nfcReadPagePkg::waitBusy;
                end
            end
            // flash must first report busy for the array read
            nfcReadPagePkg::waitBusy: begin
                if (!wayReady) begin
                    nextState = nfcReadPagePkg::waitReady;
                end
            end
            nfcReadPagePkg::waitReady: begin
                if (wayReady) begin
                    nextState = nfcReadPagePkg::dataIssue;
                end
            end
            // leave one cycle after the completion pulse
            nfcReadPagePkg::dataIssue: begin
                if (lastStep) begin
                    nextState = nfcReadPagePkg::idle;
                end
            end
            default: begin
                nextState = nfcReadPagePkg::idle;
            end
        endcase
    end

    // outputs follow the state being entered
    always_ff @(posedge iSystemClock) begin
        if (rst) begin
            cmdReady               <= 1'b1;
            transValid             <= 1'b0;
            lastStep               <= 1'b0;
            engineReq.engineSelect <= '0;
            engineReq.targetWay    <= '0;
            engineReq.byteCount    <= '0;
            engineReq.caSelect     <= 1'b1;
            engineReq.caData       <= '0;
        end else begin
            // quiet bus unless a phase below says otherwise
            cmdReady               <= 1'b0;
            transValid             <= 1'b0;
            lastStep               <= 1'b0;
            engineReq.engineSelect <= '0;
            engineReq.targetWay    <= targetWay;
            engineReq.byteCount    <= '0;
            engineReq.caSelect     <= 1'b1;
            engineReq.caData       <= '0;

            case (nextState)
                nfcReadPagePkg::idle: begin
                    cmdReady <= 1'b1;
                end
                // 00h first command cycle
                nfcReadPagePkg::cmdIssue: begin
                    engineReq.engineSelect <= cmdAddrSelect;
                end
                nfcReadPagePkg::addrIssue: begin
                    engineReq.engineSelect <= cmdAddrSelect;
                    engineReq.byteCount    <= nfcReadPagePkg::ADDRESS_COUNT_CODE;
                    engineReq.caSelect     <= 1'b0;
                    engineReq.caData       <= addressBytes;
                end
                nfcReadPagePkg::cmd2Issue: begin
                    engineReq.engineSelect <= cmdAddrSelect;
                    engineReq.caData       <= {nfcReadPagePkg::READ_CONFIRM_BYTE, 32'h0};
                end
                nfcReadPagePkg::dataIssue: begin
                    engineReq.byteCount <= length;
                    engineReq.caSelect  <= 1'b0;
                    // pulse only on the way in
                    transValid <= (state == nfcReadPagePkg::waitReady);
                    if (state == nfcReadPagePkg::dataIssue && dataDone) begin
                        lastStep <= 1'b1;
                    end else begin
                        engineReq.engineSelect <= dataInSelect;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/nfcReadPageCmd.sv
`timescale 1ns/100ps
`default_nettype none

module nfcReadPageCmd (
    input  wire                                iSystemClock,
    input  wire                                rst,
    input  wire nfcReadPagePkg::hostCommand_t  command,
    input  wire                                cmdValid,
    output logic                               cmdReady,
    output logic                               start,
    output logic                               transValid,
    output logic                               lastStep,
    output nfcReadPagePkg::engineRequest_t     engineReq,
    input  wire nfcReadPagePkg::engineSelect_t engineDone,
    input  wire nfcReadPagePkg::wayMask_t      readyBusy
);

    logic                        capture;
    logic                        wayReady;
    nfcReadPagePkg::wayMask_t    targetWay;
    nfcReadPagePkg::dataLength_t length;
    nfcReadPagePkg::caData_t     addressBytes;

    // phase control and all registered outputs
    readPageSequencer sequencer0 (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .cmdOpcode    (command.opcode),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .start        (start),
        .capture      (capture),
        .targetWay    (targetWay),
        .length       (length),
        .addressBytes (addressBytes),
        .wayReady     (wayReady),
        .engineDone   (engineDone),
        .engineReq    (engineReq),
        .transValid   (transValid),
        .lastStep     (lastStep)
    );

    commandLatch latch0 (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .capture      (capture),
        .command      (command),
        .targetWay    (targetWay),
        .length       (length),
        .addressBytes (addressBytes)
    );

    // ready/busy of the addressed ways only
    readyBusyMonitor monitor0 (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .targetWay    (targetWay),
        .readyBusy    (readyBusy),
        .wayReady     (wayReady)
    );

endmodule

`default_nettype wire

// File: verif/readPageChk.sv
`timescale 1ns/100ps
`default_nettype none

module readPageChk (
    input wire                                iSystemClock,
    input wire                                rst,
    input wire                                cmdReady,
    input wire                                start,
    input wire                                transValid,
    input wire                                lastStep,
    input wire nfcReadPagePkg::engineSelect_t engineSelect
);

    // status pulses are single cycle
    transValidPulse: assert property (@(posedge iSystemClock) disable iff (rst)
        transValid |=> !transValid)
        else $error("transValid held for two cycles");

    lastStepPulse: assert property (@(posedge iSystemClock) disable iff (rst)
        lastStep |=> !lastStep)
        else $error("lastStep held for two cycles");

    // busy while any engine is requested
    busyWhileEngine: assert property (@(posedge iSystemClock) disable iff (rst)
        (engineSelect != '0) |-> !cmdReady)
        else $error("cmdReady high with an engine selected");

    // accepted only while ready, busy from the next cycle
    startOnlyWhenReady: assert property (@(posedge iSystemClock) disable iff (rst)
        start |-> cmdReady ##1 !cmdReady)
        else $error("start while cmdReady low or cmdReady still high after start");

endmodule

`default_nettype wire

// File: verif/readPageScoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module readPageScoreboard (
    input  wire                                iSystemClock,
    input  wire                                rst,
    input  wire nfcReadPagePkg::hostCommand_t  command,
    input  wire                                cmdValid,
    input  wire                                cmdReady,
    input  wire                                start,
    input  wire                                transValid,
    input  wire                                lastStep,
    input  wire nfcReadPagePkg::engineRequest_t engineReq,
    input  wire nfcReadPagePkg::engineSelect_t engineDone,
    input  wire nfcReadPagePkg::wayMask_t      readyBusy,
    output int                                 errorCount
);

    typedef enum int {
        mIdle, mCapture, mCmd, mAddr, mConfirm, mWaitLow, mWaitHigh, mData, mLast
    } modelPhase_t;

    modelPhase_t                    phase;
    modelPhase_t                    prevPhase;
    nfcReadPagePkg::wayMask_t       way;
    nfcReadPagePkg::wayMask_t       oldWay;
    nfcReadPagePkg::wayMask_t       stage;
    nfcReadPagePkg::dataLength_t    len;
    nfcReadPagePkg::caData_t        bytes;
    logic                           wayReady;
    logic                           expReady;
    logic                           accept;
    nfcReadPagePkg::engineRequest_t exp;

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            errorCount = errorCount + 1;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic resetModel();
        phase    = mIdle;
        way      = '0;
        stage    = '1;
        wayReady = 1'b1;
        len      = '0;
        bytes    = '0;
        expReady = 1'b1;
        exp      = '0;
        exp.caSelect = 1'b1;
    endtask

    // one clock edge of the reference behavior
    task automatic stepModel();
        logic oldReady;
        oldReady  = wayReady;
        oldWay    = way;
        accept    = expReady && cmdValid &&
                    (command.opcode == nfcReadPagePkg::READ_PAGE_OPCODE);
        // two register stages on the masked lines
        wayReady  = |stage;
        stage     = way & readyBusy;
        prevPhase = phase;
        case (phase)
            mIdle:     if (accept) phase = mCapture;
            mCapture:  phase = mCmd;
            mCmd:      if (engineDone[3]) phase = mAddr;
            mAddr:     if (engineDone[3]) phase = mConfirm;
            mConfirm:  if (engineDone[3]) phase = mWaitLow;
            mWaitLow:  if (!oldReady) phase = mWaitHigh;
            mWaitHigh: if (oldReady) phase = mData;
            mData:     if (engineDone[1]) phase = mLast;
            default:   phase = mIdle;
        endcase
        if (accept) begin
            way   = command.waySelect;
            len   = command.length;
            // column low, column high, then row low to high
            bytes = {command.colAddress[7:0], command.colAddress[15:8],
                     command.rowAddress[7:0], command.rowAddress[15:8],
                     command.rowAddress[23:16]};
        end
        exp           = '0;
        exp.targetWay = oldWay;
        exp.caSelect  = 1'b1;
        expReady      = (phase == mIdle);
        case (phase)
            mCmd:     exp.engineSelect = 8'h08;
            mAddr: begin
                exp.engineSelect = 8'h08;
                exp.byteCount    = 16'd4;
                exp.caSelect     = 1'b0;
                exp.caData       = bytes;
            end
            mConfirm: begin
                exp.engineSelect = 8'h08;
                exp.caData       = {8'h30, 32'h0};
            end
            mData, mLast: begin
                exp.engineSelect = (phase == mData) ? 8'h02 : 8'h00;
                exp.byteCount    = len;
                exp.caSelect     = 1'b0;
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        errorCount = 0;
        resetModel();
    end

    // mid high phase, inputs and outputs both settled
    always @(posedge iSystemClock) begin
        #5;
        if (rst) begin
            resetModel();
        end else begin
            stepModel();
            compare("cmdReady", 64'(cmdReady), 64'(expReady));
            compare("transValid", 64'(transValid),
                    64'(phase == mData && prevPhase == mWaitHigh));
            compare("lastStep", 64'(lastStep), 64'(phase == mLast));
            compare("engineSelect", 64'(engineReq.engineSelect), 64'(exp.engineSelect));
            compare("targetWay", 64'(engineReq.targetWay), 64'(exp.targetWay));
            compare("byteCount", 64'(engineReq.byteCount), 64'(exp.byteCount));
            compare("caSelect", 64'(engineReq.caSelect), 64'(exp.caSelect));
            compare("caData", 64'(engineReq.caData), 64'(exp.caData));
            compare("start", 64'(start), 64'(expReady && cmdValid &&
                    command.opcode == nfcReadPagePkg::READ_PAGE_OPCODE));
        end
    end

endmodule

`default_nettype wire

// File: verif/tbNfcReadPage.sv
`timescale 1ns/100ps
`default_nettype none

module tbNfcReadPage;

    logic                           iSystemClock;
    logic                           rst;
    nfcReadPagePkg::hostCommand_t   command;
    logic                           cmdValid;
    logic                           cmdReady;
    logic                           start;
    logic                           transValid;
    logic                           lastStep;
    nfcReadPagePkg::engineRequest_t engineReq;
    nfcReadPagePkg::engineSelect_t  engineDone;
    nfcReadPagePkg::wayMask_t       readyBusy;
    logic                           doneCa;
    logic                           doneData;
    nfcReadPagePkg::wayMask_t       busyMask;
    nfcReadPagePkg::wayMask_t       noise;
    nfcReadPagePkg::wayMask_t       addressedWay;
    integer                         seed;
    int                             errorCount;
    int                             numCommands;
    int                             cycleLimit;
    int                             cycles;

    assign engineDone = nfcReadPagePkg::engineSelect_t'({doneCa, 1'b0, doneData, 1'b0});
    // selected ways follow the busy model, the others are noise
    assign readyBusy = (noise & ~addressedWay) | (addressedWay & ~busyMask);

    nfcReadPageCmd dut0 (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .command      (command),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .start        (start),
        .transValid   (transValid),
        .lastStep     (lastStep),
        .engineReq    (engineReq),
        .engineDone   (engineDone),
        .readyBusy    (readyBusy)
    );

    readPageScoreboard scoreboard0 (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .command      (command),
        .cmdValid     (cmdValid),
        .cmdReady     (cmdReady),
        .start        (start),
        .transValid   (transValid),
        .lastStep     (lastStep),
        .engineReq    (engineReq),
        .engineDone   (engineDone),
        .readyBusy    (readyBusy),
        .errorCount   (errorCount)
    );

    bind readPageSequencer readPageChk chk0 (
        .iSystemClock (iSystemClock),
        .rst          (rst),
        .cmdReady     (cmdReady),
        .start        (start),
        .transValid   (transValid),
        .lastStep     (lastStep),
        .engineSelect (engineReq.engineSelect)
    );

    function automatic int randBelow(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    function automatic nfcReadPagePkg::hostCommand_t randomCommand(input logic goodOp);
        nfcReadPagePkg::hostCommand_t c;
        c.opcode     = goodOp ? nfcReadPagePkg::READ_PAGE_OPCODE : 6'($random(seed));
        if (!goodOp && c.opcode == nfcReadPagePkg::READ_PAGE_OPCODE) begin
            c.opcode = c.opcode ^ 6'h20;
        end
        c.length     = 16'($random(seed));
        c.colAddress = 16'($random(seed));
        c.rowAddress = 24'($random(seed));
        c.waySelect  = 4'($random(seed));
        // an empty way mask would never see busy
        if (c.waySelect == '0) begin
            c.waySelect = 4'b0001;
        end
        return c;
    endfunction

    task automatic sendCommand();
        logic goodOp;
        repeat (randBelow(4)) @(negedge iSystemClock);
        while (!cmdReady) @(negedge iSystemClock);
        goodOp   = (randBelow(5) != 0);
        command  = randomCommand(goodOp);
        cmdValid = 1'b1;
        @(negedge iSystemClock);
        cmdValid = 1'b0;
        // stray requests while busy are dropped
        while (!cmdReady) begin
            cmdValid = (randBelow(7) == 0);
            command  = randomCommand(1'b1);
            @(negedge iSystemClock);
        end
        cmdValid = 1'b0;
    endtask

    initial begin
        iSystemClock = 1'b0;
        forever #10 iSystemClock = ~iSystemClock;
    end

    // cmd/addr engine
    initial begin
        doneCa = 1'b0;
        forever begin
            @(negedge iSystemClock);
            if (engineReq.engineSelect[nfcReadPagePkg::ENGINE_CMD_ADDR]) begin
                repeat (1 + randBelow(8)) @(negedge iSystemClock);
                doneCa = 1'b1;
                @(negedge iSystemClock);
                doneCa = 1'b0;
                repeat (2) @(negedge iSystemClock);
            end
        end
    end

    // data engine
    initial begin
        doneData = 1'b0;
        forever begin
            @(negedge iSystemClock);
            if (engineReq.engineSelect[nfcReadPagePkg::ENGINE_DATA_IN]) begin
                repeat (1 + randBelow(8)) @(negedge iSystemClock);
                doneData = 1'b1;
                @(negedge iSystemClock);
                doneData = 1'b0;
                repeat (2) @(negedge iSystemClock);
            end
        end
    end

    // flash array read after the 30h confirm
    initial begin
        busyMask = '0;
        forever begin
            @(negedge iSystemClock);
            if (engineReq.engineSelect[nfcReadPagePkg::ENGINE_CMD_ADDR] &&
                engineReq.caData[39:32] == nfcReadPagePkg::READ_CONFIRM_BYTE) begin
                while (engineReq.engineSelect != '0) @(negedge iSystemClock);
                repeat (randBelow(8)) @(negedge iSystemClock);
                busyMask = engineReq.targetWay;
                repeat (3 + randBelow(10)) @(negedge iSystemClock);
                busyMask = '0;
            end
        end
    end

    // addressed ways picked up on the falling edge with the noise
    initial begin
        noise        = '1;
        addressedWay = '0;
        forever begin
            @(negedge iSystemClock);
            noise        = 4'($random(seed));
            addressedWay = engineReq.targetWay;
        end
    end

    // about 100 cycles per command covers the slowest engine and flash delays
    always @(posedge iSystemClock) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: no finish after %0d cycles, errors %0d", cycles, errorCount);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed        = 32'hcb3e_a3ba;
        numCommands = 40;
        cycleLimit  = numCommands * 100;
        cycles      = 0;
        rst         = 1'b1;
        cmdValid    = 1'b0;
        command     = '0;
        repeat (3) @(posedge iSystemClock);
        @(negedge iSystemClock);
        rst = 1'b0;
        for (int i = 0; i < numCommands; i++) begin
            sendCommand();
        end
        repeat (5) @(negedge iSystemClock);
        $display("done: %0d commands, %0d cycles, %0d errors", numCommands, cycles, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
rtl/nfcReadPagePkg.sv
rtl/readyBusyMonitor.sv
rtl/commandLatch.sv
rtl/readPageSequencer.sv
rtl/nfcReadPageCmd.sv
verif/readPageChk.sv
verif/readPageScoreboard.sv
verif/tbNfcReadPage.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module tbNfcReadPage -Mdir obj_dir
	out=$$(./obj_dir/VtbNfcReadPage); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module tbNfcReadPage

clean:
	rm -rf obj_dir
